//--- source/gb_mem_map_pkg.sv
// console memory map
// region bounds and register addresses seen on the cpu bus,
// plus the flash offset used to reach the cartridge image
package gb_mem_map_pkg;

   // boot rom, mapped over the cartridge until swapped out
   localparam logic [15:0] boot_end = 16'h0103;

   // cartridge rom window
   localparam logic [15:0] cart_start = 16'h0000;
   localparam logic [15:0] cart_end = 16'h7FFF;

   // cartridge image sits right after the boot rom in flash
   localparam logic [15:0] cart_flash_offset = 16'h0104;

   // 8 KiB work ram
   localparam logic [15:0] wram_start = 16'hC000;
   localparam logic [15:0] wram_end = 16'hDFFF;

   // echo of work ram, read only here
   localparam logic [15:0] echo_start = 16'hE000;
   localparam logic [15:0] echo_end = 16'hFDFF;

   // memory mapped registers
   // joypad
   localparam logic [15:0] mmio_controller = 16'hFF00;
   // interrupt flags
   localparam logic [15:0] mmio_if = 16'hFF0F;
   // boot rom swap
   localparam logic [15:0] mmio_bootstrap = 16'hFF50;

   // no buttons wired, every line reads released
   localparam logic [7:0] controller_idle = 8'hFF;

endpackage

//--- source/gb_bus_pkg.sv
// bus types
// widths of the cpu bus, the flash port and the work ram offset,
// the decoded region codes and the interrupt bit positions
package gb_bus_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0] data_t;
   typedef logic [23:0] flash_addr_t;
   // offset into the 8 KiB work ram
   typedef logic [12:0] wram_addr_t;
   typedef logic [4:0] irq_t;

   // where a request lands after decode
   typedef enum logic [2:0] {
      region_boot,
      region_cart,
      region_wram,
      region_echo,
      region_bootstrap,
      region_if,
      region_controller,
      region_junk
   } region_e;

   // interrupt flag bit positions
   localparam int irq_vblank = 0;
   localparam int irq_lcdc = 1;
   localparam int irq_tima = 2;
   localparam int irq_serial = 3;
   localparam int irq_hilo = 4;

endpackage

//--- source/mem_stage_if.sv
// one decoded bus request between two pipeline stages
// the producing stage drives everything, the next stage only reads
interface mem_stage_if;

   logic                  valid;
   logic                  we;
   gb_bus_pkg::region_e   region;
   gb_bus_pkg::addr_t     addr;
   gb_bus_pkg::data_t     wdata;
   gb_bus_pkg::wram_addr_t wram_addr;
   // bootstrap bit at decode time
   logic                  boot_off;
   // read data slot, filled as the request moves along
   gb_bus_pkg::data_t     rd_byte;

   modport source (
      output valid, we, region, addr, wdata, wram_addr, boot_off, rd_byte
   );

   modport sink (
      input valid, we, region, addr, wdata, wram_addr, boot_off, rd_byte
   );

endinterface

//--- source/addr_decoder.sv
// address decoder, first bus stage
// classifies each request against the memory map, keeps the bootstrap
// register and drives the flash address from the registered request
module addr_decoder (
   input  logic                    clock,
   input  logic                    reset,
   input  gb_bus_pkg::addr_t       addr,
   input  gb_bus_pkg::data_t       wdata,
   input  logic                    we,
   input  logic                    re,
   mem_stage_if.source             s1,
   output gb_bus_pkg::flash_addr_t flash_a
);

   gb_bus_pkg::data_t   boot_q;
   gb_bus_pkg::region_e region_d;
   gb_bus_pkg::addr_t   wram_off;

   // inclusive range check as an offset compare
   function automatic logic in_range(gb_bus_pkg::addr_t a, gb_bus_pkg::addr_t lo,
                                     gb_bus_pkg::addr_t hi);
      return (a - lo) <= (hi - lo);
   endfunction

   // region decode, boot rom first while it is still mapped
   always_comb begin
      if (!boot_q[0] && addr <= gb_mem_map_pkg::boot_end) begin
         region_d = gb_bus_pkg::region_boot;
      end else if (in_range(addr, gb_mem_map_pkg::cart_start, gb_mem_map_pkg::cart_end)) begin
         region_d = gb_bus_pkg::region_cart;
      end else if (in_range(addr, gb_mem_map_pkg::wram_start, gb_mem_map_pkg::wram_end)) begin
         region_d = gb_bus_pkg::region_wram;
      end else if (in_range(addr, gb_mem_map_pkg::echo_start, gb_mem_map_pkg::echo_end)) begin
         region_d = gb_bus_pkg::region_echo;
      end else if (addr == gb_mem_map_pkg::mmio_bootstrap) begin
         region_d = gb_bus_pkg::region_bootstrap;
      end else if (addr == gb_mem_map_pkg::mmio_if) begin
         region_d = gb_bus_pkg::region_if;
      end else if (addr == gb_mem_map_pkg::mmio_controller) begin
         region_d = gb_bus_pkg::region_controller;
      end else begin
         // video, sound, timers and holes
         region_d = gb_bus_pkg::region_junk;
      end
   end

   // echo folds onto the same 8 KiB as work ram
   assign wram_off = (region_d == gb_bus_pkg::region_echo) ?
                     addr - gb_mem_map_pkg::echo_start :
                     addr - gb_mem_map_pkg::wram_start;

   // stage valid and bootstrap register
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         s1.valid <= 1'b0;
         boot_q <= '0;
      end else begin
         s1.valid <= we | re;
         // write wins over a read in the same cycle
         if (we && addr == gb_mem_map_pkg::mmio_bootstrap) begin
            boot_q <= wdata;
         end
      end
   end

   // request payload
   always_ff @(posedge clock) begin
      s1.we <= we;
      s1.region <= region_d;
      s1.addr <= addr;
      s1.wdata <= wdata;
      s1.wram_addr <= wram_off[12:0];
      s1.boot_off <= boot_q[0];
      // register snapshot rides along for a bootstrap read
      s1.rd_byte <= boot_q;
   end

   // cartridge reads skip the boot image in flash
   assign flash_a = (s1.region == gb_bus_pkg::region_cart) ?
                    {8'h00, s1.addr + gb_mem_map_pkg::cart_flash_offset} :
                    {8'h00, s1.addr};

endmodule

//--- source/work_ram.sv
// work ram stage
// 8 KiB synchronous ram with the echo window aliased onto it,
// also captures the flash byte and forwards the request to the last stage
module work_ram (
   input  logic        clock,
   input  logic        reset,
   mem_stage_if.sink   s1,
   input  logic [15:0] flash_d,
   mem_stage_if.source s2
);

   gb_bus_pkg::data_t mem [0:(1 << $bits(gb_bus_pkg::wram_addr_t)) - 1];
   gb_bus_pkg::data_t ram_q;
   gb_bus_pkg::data_t byte_q;
   logic              flash_hit;
   logic              wr_en;

   assign flash_hit = (s1.region == gb_bus_pkg::region_boot) ||
                      (s1.region == gb_bus_pkg::region_cart);

   // echo writes are dropped, only the real window stores
   assign wr_en = s1.valid && s1.we && (s1.region == gb_bus_pkg::region_wram);

   // ram port, read before write
   always_ff @(posedge clock) begin
      if (wr_en) begin
         mem[s1.wram_addr] <= s1.wdata;
      end
      ram_q <= mem[s1.wram_addr];
   end

   // flash answers within the cycle
   // other regions keep the slot from decode
   always_ff @(posedge clock) begin
      byte_q <= flash_hit ? flash_d[7:0] : s1.rd_byte;
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         s2.valid <= 1'b0;
      end else begin
         s2.valid <= s1.valid;
      end
   end

   // payload, one cycle behind s1
   always_ff @(posedge clock) begin
      s2.we <= s1.we;
      s2.region <= s1.region;
      s2.addr <= s1.addr;
      s2.wdata <= s1.wdata;
      s2.wram_addr <= s1.wram_addr;
      s2.boot_off <= s1.boot_off;
   end

   // ram output picked after the register
   assign s2.rd_byte = (s2.region == gb_bus_pkg::region_wram ||
                        s2.region == gb_bus_pkg::region_echo) ? ram_q : byte_q;

endmodule

//--- source/read_return.sv
// read return stage
// holds the interrupt flag register and registers the read data
// multiplexer, with one valid pulse per completed read
module read_return (
   input  logic              clock,
   input  logic              reset,
   mem_stage_if.sink         s2,
   input  gb_bus_pkg::irq_t  irq,
   output gb_bus_pkg::data_t rdata,
   output logic              rdata_valid
);

   gb_bus_pkg::irq_t  if_q;
   gb_bus_pkg::irq_t  irq_set;
   gb_bus_pkg::irq_t  if_wr;
   gb_bus_pkg::data_t boot_val;
   logic              if_load;
   logic              rd_done;

   // only vblank, lcdc and tima have sources
   // serial and hilo stay clear
   always_comb begin
      irq_set = '0;
      irq_set[gb_bus_pkg::irq_vblank] = irq[gb_bus_pkg::irq_vblank];
      irq_set[gb_bus_pkg::irq_lcdc] = irq[gb_bus_pkg::irq_lcdc];
      irq_set[gb_bus_pkg::irq_tima] = irq[gb_bus_pkg::irq_tima];
   end

   // cpu write, same bits as the request lines
   always_comb begin
      if_wr = '0;
      if_wr[gb_bus_pkg::irq_vblank] = s2.wdata[gb_bus_pkg::irq_vblank];
      if_wr[gb_bus_pkg::irq_lcdc] = s2.wdata[gb_bus_pkg::irq_lcdc];
      if_wr[gb_bus_pkg::irq_tima] = s2.wdata[gb_bus_pkg::irq_tima];
   end

   assign if_load = s2.valid && s2.we && (s2.region == gb_bus_pkg::region_if);

   // write wins, so no data for a combined strobe
   assign rd_done = s2.valid && !s2.we;

   // upper bits come through the data slot
   // bit 0 is the live swap bit
   assign boot_val = {s2.rd_byte[7:1], s2.boot_off};

   // flag register
   // a write replaces it, request lines otherwise accumulate
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_q <= '0;
      end else if (if_load) begin
         if_q <= if_wr;
      end else begin
         if_q <= if_q | irq_set;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rdata_valid <= 1'b0;
      end else begin
         rdata_valid <= rd_done;
      end
   end

   // read multiplexer
   // held between reads
   always_ff @(posedge clock) begin
      if (rd_done) begin
         case (s2.region)
            gb_bus_pkg::region_bootstrap: rdata <= boot_val;
            gb_bus_pkg::region_if: rdata <= {3'b000, if_q};
            gb_bus_pkg::region_controller: rdata <= gb_mem_map_pkg::controller_idle;
            gb_bus_pkg::region_junk: rdata <= '0;
            // boot, cart, wram and echo bytes
            default: rdata <= s2.rd_byte;
         endcase
      end
   end

endmodule

//--- source/gb_bus_top.sv
// console memory bus, top level
// decode, work ram and read return stages in a three stage pipeline,
// flash address out and flash data in for boot rom and cartridge
module gb_bus_top (
   input  logic                    clock,
   input  logic                    reset,
   input  gb_bus_pkg::addr_t       addr,
   input  gb_bus_pkg::data_t       wdata,
   input  logic                    we,
   input  logic                    re,
   input  gb_bus_pkg::irq_t        irq,
   input  logic [15:0]             flash_d,
   output gb_bus_pkg::flash_addr_t flash_a,
   output gb_bus_pkg::data_t       rdata,
   output logic                    rdata_valid
);

   // decoder to ram stage
   mem_stage_if s1 ();
   // ram stage to read return
   mem_stage_if s2 ();

   addr_decoder u_addr_decoder (
      .clock   (clock),
      .reset   (reset),
      .addr    (addr),
      .wdata   (wdata),
      .we      (we),
      .re      (re),
      .s1      (s1.source),
      .flash_a (flash_a)
   );

   work_ram u_work_ram (
      .clock   (clock),
      .reset   (reset),
      .s1      (s1.sink),
      .flash_d (flash_d),
      .s2      (s2.source)
   );

   read_return u_read_return (
      .clock       (clock),
      .reset       (reset),
      .s2          (s2.sink),
      .irq         (irq),
      .rdata       (rdata),
      .rdata_valid (rdata_valid)
   );

endmodule

//--- sim/gb_bus_asserts.sv
// bus protocol assertions, bound into the read return stage
// valid pulse held low in reset, no data after a write,
// and the two interrupt flags that have no request line
module gb_bus_asserts (
   input logic             clock,
   input logic             reset,
   input logic             s2_valid,
   input logic             s2_we,
   input gb_bus_pkg::irq_t if_q,
   input logic             rdata_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   // running count of failed assertions
   int unsigned failures = 0;

   valid_low_in_reset: assert property (@(posedge clock) reset |-> !rdata_valid)
      else begin
         failures++;
         $error("rdata_valid high while reset is asserted");
      end

   // a write in the last stage never returns data
   no_valid_after_write: assert property (@(posedge clock) disable iff (reset)
      (s2_valid && s2_we) |=> !rdata_valid)
      else begin
         failures++;
         $error("rdata_valid pulse after a write");
      end

   unsourced_irq_clear: assert property (@(posedge clock) disable iff (reset)
      !if_q[gb_bus_pkg::irq_serial] && !if_q[gb_bus_pkg::irq_hilo])
      else begin
         failures++;
         $error("serial or hilo interrupt flag set");
      end

endmodule

bind read_return gb_bus_asserts u_gb_bus_asserts (
   .clock       (clock),
   .reset       (reset),
   .s2_valid    (s2.valid),
   .s2_we       (s2.we),
   .if_q        (if_q),
   .rdata_valid (rdata_valid)
);

//--- sim/bus_checker.sv
// bus checker
// pairs every rdata_valid pulse with the oldest outstanding read,
// compares data, latency and flash address and keeps the error count
module bus_checker (
   input logic                    clock,
   input logic                    reset,
   input gb_bus_pkg::addr_t       addr,
   input logic                    we,
   input logic                    re,
   input gb_bus_pkg::flash_addr_t flash_a,
   input gb_bus_pkg::data_t       rdata,
   input logic                    rdata_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   // expected bytes from the reference model, oldest first
   gb_bus_pkg::data_t expected_q [$];
   // expected flash address of each read, checked while it sits in s1
   gb_bus_pkg::flash_addr_t flash_q [$];
   // edge number and address of each read the DUT accepted
   int unsigned       issue_q [$];
   gb_bus_pkg::addr_t addr_q [$];
   int unsigned       cycle = 0;
   int unsigned       error_count = 0;
   int unsigned       read_count = 0;
   // a read was accepted on the latest edge
   logic              read_seen = 1'b0;
   gb_bus_pkg::data_t exp_byte;
   gb_bus_pkg::addr_t exp_addr;
   gb_bus_pkg::flash_addr_t exp_flash;
   int unsigned       issued;

   task automatic expect_read(input gb_bus_pkg::data_t value);
      expected_q.push_back(value);
   endtask

   task automatic expect_flash(input gb_bus_pkg::flash_addr_t fa);
      flash_q.push_back(fa);
   endtask

   function automatic int unsigned pending();
      return expected_q.size();
   endfunction

   // requests sampled on the same edge as the DUT
   always @(posedge clock) begin
      cycle = cycle + 1;
      read_seen = !reset && re && !we;
      if (read_seen) begin
         issue_q.push_back(cycle);
         addr_q.push_back(addr);
      end
   end

   // flash address follows the decoded request within the cycle
   always @(negedge clock) begin
      if (read_seen) begin
         if (flash_q.size() == 0) begin
            error_count++;
            $display("read accepted at %0t with no flash address expected", $time);
         end else begin
            exp_flash = flash_q.pop_front();
            if (flash_a !== exp_flash) begin
               error_count++;
               $display("CHECK FAILED at %0t: flash address %h, expected %h",
                        $time, flash_a, exp_flash);
            end
         end
      end
   end

   // registered outputs are settled by the falling edge
   always @(negedge clock) begin
      if (!reset && rdata_valid) begin
         if (issue_q.size() == 0 || expected_q.size() == 0) begin
            error_count++;
            $display("rdata_valid pulse at %0t with no read outstanding", $time);
         end else begin
            exp_byte = expected_q.pop_front();
            exp_addr = addr_q.pop_front();
            issued = issue_q.pop_front();
            read_count++;
            if (rdata !== exp_byte) begin
               error_count++;
               $display("CHECK FAILED at %0t: read of %h returned %h, expected %h",
                        $time, exp_addr, rdata, exp_byte);
            end
            // two edges from request to data
            if (cycle - issued != 2) begin
               error_count++;
               $display("CHECK FAILED at %0t: read of %h took %0d cycles, expected 2",
                        $time, exp_addr, cycle - issued);
            end
         end
      end
   end

   task automatic report(input int unsigned timeouts, input int unsigned assert_fails);
      $display("reads checked %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
               read_count, error_count, timeouts, assert_fails);
   endtask

endmodule

//--- sim/tb_gb_bus.sv
// memory bus testbench
// drives boot mapping, bootstrap swap, work ram, read bursts,
// interrupt flags and fixed registers against a combinational flash model
module tb_gb_bus;
   timeunit 1ns;
   timeprecision 100ps;

   logic                    clock;
   logic                    reset;
   gb_bus_pkg::addr_t       addr;
   gb_bus_pkg::data_t       wdata;
   logic                    we;
   logic                    re;
   gb_bus_pkg::irq_t        irq;
   logic [15:0]             flash_d;
   gb_bus_pkg::flash_addr_t flash_a;
   gb_bus_pkg::data_t       rdata;
   logic                    rdata_valid;

   // reference state
   gb_bus_pkg::data_t model_ram [0:8191];
   gb_bus_pkg::data_t model_boot;
   gb_bus_pkg::irq_t  model_if;
   gb_bus_pkg::addr_t wram_list [0:15];
   int unsigned       timeouts;
   int unsigned       wait_cycles;
   int unsigned       assert_fails;

   gb_bus_top u_gb_bus_top (
      .clock       (clock),
      .reset       (reset),
      .addr        (addr),
      .wdata       (wdata),
      .we          (we),
      .re          (re),
      .irq         (irq),
      .flash_d     (flash_d),
      .flash_a     (flash_a),
      .rdata       (rdata),
      .rdata_valid (rdata_valid)
   );

   bus_checker u_bus_checker (
      .clock       (clock),
      .reset       (reset),
      .addr        (addr),
      .we          (we),
      .re          (re),
      .flash_a     (flash_a),
      .rdata       (rdata),
      .rdata_valid (rdata_valid)
   );

   // flash image is the address scrambled with a fixed pattern
   assign flash_d = flash_a[15:0] ^ 16'h5A5A;

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   function automatic gb_bus_pkg::data_t flash_byte(input logic [15:0] fa);
      return fa[7:0] ^ 8'h5A;
   endfunction

   // cartridge reads move past the boot image, everything else passes through
   function automatic gb_bus_pkg::flash_addr_t expected_flash(input gb_bus_pkg::addr_t a);
      gb_bus_pkg::flash_addr_t fa;
      fa = 24'(a);
      if (a <= gb_mem_map_pkg::cart_end && (model_boot[0] || a > gb_mem_map_pkg::boot_end)) begin
         fa = fa + 24'(gb_mem_map_pkg::cart_flash_offset);
      end
      return fa;
   endfunction

   // serial and hilo have no source
   function automatic gb_bus_pkg::irq_t settable(input gb_bus_pkg::irq_t v);
      gb_bus_pkg::irq_t m;
      m = v;
      m[gb_bus_pkg::irq_serial] = 1'b0;
      m[gb_bus_pkg::irq_hilo] = 1'b0;
      return m;
   endfunction

   // expected read byte from the memory map rules
   function automatic gb_bus_pkg::data_t expected_byte(input gb_bus_pkg::addr_t a);
      gb_bus_pkg::addr_t off;
      if (!model_boot[0] && a <= gb_mem_map_pkg::boot_end) begin
         return flash_byte(a);
      end
      if (a <= gb_mem_map_pkg::cart_end) begin
         return flash_byte(a + gb_mem_map_pkg::cart_flash_offset);
      end
      if (a >= gb_mem_map_pkg::wram_start && a <= gb_mem_map_pkg::wram_end) begin
         off = a - gb_mem_map_pkg::wram_start;
         return model_ram[off[12:0]];
      end
      if (a >= gb_mem_map_pkg::echo_start && a <= gb_mem_map_pkg::echo_end) begin
         off = a - gb_mem_map_pkg::echo_start;
         return model_ram[off[12:0]];
      end
      if (a == gb_mem_map_pkg::mmio_bootstrap) begin
         return model_boot;
      end
      if (a == gb_mem_map_pkg::mmio_if) begin
         return {3'b000, model_if};
      end
      if (a == gb_mem_map_pkg::mmio_controller) begin
         return gb_mem_map_pkg::controller_idle;
      end
      // video, sound, timers and holes
      return 8'h00;
   endfunction

   // echo writes fall through and change nothing
   task automatic model_write(input gb_bus_pkg::addr_t a, input gb_bus_pkg::data_t d);
      gb_bus_pkg::addr_t off;
      off = a - gb_mem_map_pkg::wram_start;
      if (a >= gb_mem_map_pkg::wram_start && a <= gb_mem_map_pkg::wram_end) begin
         model_ram[off[12:0]] = d;
      end else if (a == gb_mem_map_pkg::mmio_bootstrap) begin
         model_boot = d;
      end else if (a == gb_mem_map_pkg::mmio_if) begin
         model_if = settable(d[4:0]);
      end
   endtask

   task automatic drive(input gb_bus_pkg::addr_t a, input gb_bus_pkg::data_t d,
                        input logic w, input logic r);
      @(posedge clock);
      #1;
      addr = a;
      wdata = d;
      we = w;
      re = r;
   endtask

   task automatic bus_write(input gb_bus_pkg::addr_t a, input gb_bus_pkg::data_t d);
      drive(a, d, 1'b1, 1'b0);
      model_write(a, d);
   endtask

   task automatic bus_read(input gb_bus_pkg::addr_t a);
      drive(a, 8'($urandom()), 1'b0, 1'b1);
      u_bus_checker.expect_flash(expected_flash(a));
      u_bus_checker.expect_read(expected_byte(a));
   endtask

   task automatic bus_idle(input int cycles);
      repeat (cycles) begin
         drive(addr, wdata, 1'b0, 1'b0);
      end
   endtask

   task automatic pulse_irq(input gb_bus_pkg::irq_t bits);
      drive(addr, wdata, 1'b0, 1'b0);
      irq = bits;
      model_if = model_if | settable(bits);
      @(posedge clock);
      #1;
      irq = '0;
   endtask

   // cartridge, work ram, echo and junk addresses mixed
   function automatic gb_bus_pkg::addr_t burst_addr();
      gb_bus_pkg::addr_t pick;
      case ($urandom_range(0, 3))
         0: pick = 16'($urandom_range(0, 16'h7FFF));
         1: pick = wram_list[$urandom_range(0, 15)];
         2: pick = wram_list[$urandom_range(0, 15)] + 16'h2000;
         default: pick = 16'h8000 + 16'($urandom_range(0, 16'h3FFF));
      endcase
      return pick;
   endfunction

   initial begin
      void'($urandom(73925));
      reset = 1'b1;
      addr = '0;
      wdata = '0;
      we = 1'b0;
      re = 1'b0;
      irq = '0;
      model_boot = '0;
      model_if = '0;
      timeouts = 0;
      repeat (8) @(posedge clock);
      #1;
      reset = 1'b0;

      // boot rom still mapped over the low cartridge
      bus_read(16'h0000);
      bus_read(16'h0103);
      bus_read(16'h0104);
      bus_read(16'h7FFF);
      for (int i = 0; i < 8; i++) begin
         bus_read(16'($urandom_range(0, 16'h7FFF)));
      end

      // swap the boot rom out
      bus_write(gb_mem_map_pkg::mmio_bootstrap, 8'h01);
      bus_read(gb_mem_map_pkg::mmio_bootstrap);
      bus_read(16'h0000);
      bus_read(16'h0103);

      // addresses below 0xDE00 so each one has an echo
      for (int i = 0; i < 16; i++) begin
         wram_list[i] = gb_mem_map_pkg::wram_start + 16'($urandom_range(0, 16'h1DFF));
         bus_write(wram_list[i], 8'($urandom()));
      end
      for (int i = 0; i < 16; i++) begin
         bus_read(wram_list[i]);
         bus_read(wram_list[i] + 16'h2000);
      end
      for (int i = 0; i < 4; i++) begin
         bus_write(wram_list[i] + 16'h2000, 8'($urandom()));
         bus_read(wram_list[i]);
      end

      // both strobes high stores the byte and returns nothing
      drive(wram_list[0], 8'hA5, 1'b1, 1'b1);
      model_write(wram_list[0], 8'hA5);
      for (int i = 0; i < 40; i++) begin
         bus_read(burst_addr());
      end

      // interrupt flags
      bus_idle(2);
      pulse_irq(5'b00100);
      bus_idle(2);
      bus_read(gb_mem_map_pkg::mmio_if);
      bus_write(gb_mem_map_pkg::mmio_if, 8'h00);
      bus_read(gb_mem_map_pkg::mmio_if);
      bus_idle(2);
      pulse_irq(5'b11000);
      bus_idle(2);
      bus_read(gb_mem_map_pkg::mmio_if);

      // controller, then lcd control, sound enable and timer counter
      bus_read(gb_mem_map_pkg::mmio_controller);
      bus_read(16'hFF40);
      bus_read(16'hFF26);
      bus_read(16'hFF05);
      bus_idle(1);

      wait_cycles = 0;
      while (u_bus_checker.pending() != 0 && wait_cycles < 64) begin
         @(posedge clock);
         wait_cycles++;
      end
      if (u_bus_checker.pending() != 0) begin
         timeouts++;
         $display("timeout after %0d cycles with %0d reads still waiting for data",
                  wait_cycles, u_bus_checker.pending());
      end
      assert_fails = u_gb_bus_top.u_read_return.u_gb_bus_asserts.failures;
      u_bus_checker.report(timeouts, assert_fails);
      if (u_bus_checker.error_count == 0 && timeouts == 0 && assert_fails == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- vlog.f
source/gb_mem_map_pkg.sv
source/gb_bus_pkg.sv
source/mem_stage_if.sv
source/addr_decoder.sv
source/work_ram.sv
source/read_return.sv
source/gb_bus_top.sv
sim/gb_bus_asserts.sv
sim/bus_checker.sv
sim/tb_gb_bus.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the memory bus testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter the project directory"
   exit 1
fi

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_gb_bus -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/Vtb_gb_bus +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
   exit 1
fi
exit 0
